/* design/textureBufferPkg.sv */
/*
 * Texture buffer shared definitions
 * Texel widths, coordinate and quad structs, bank address width
 */
`default_nettype none

package textureBufferPkg;

    localparam int pixelWidth    = 16;
    localparam int coordWidth    = 16;
    localparam int sizeCodeWidth = 8;

    // Bit 0 is the bank, then lane bits, then the bank word address
    typedef logic [15:0] texelAddrT;

    // One-hot size code per axis, bit k set means 2^(k+1) texels
    typedef struct packed {
        logic [sizeCodeWidth-1:0] sizeX;
        logic [sizeCodeWidth-1:0] sizeY;
    } textureSizeT;

    typedef struct packed {
        logic [coordWidth-1:0] x;
        logic [coordWidth-1:0] y;
    } texelCoordT;

    // Fractions left-aligned, 0x0 is 0.0 and 0xffff is just below 1.0
    typedef struct packed {
        logic [coordWidth-1:0] x;
        logic [coordWidth-1:0] y;
    } subCoordT;

    // t01 is x+1, t10 is y+1, t11 is both
    typedef struct packed {
        texelAddrT t00;
        texelAddrT t01;
        texelAddrT t10;
        texelAddrT t11;
    } quadAddrT;

    typedef struct packed {
        logic [pixelWidth-1:0] t00;
        logic [pixelWidth-1:0] t01;
        logic [pixelWidth-1:0] t10;
        logic [pixelWidth-1:0] t11;
    } texelQuadT;

    // Word address width of one bank, each bank holds half the buffer
    function automatic int bankAddrWidth(input int streamWidth, input int sizeLog2);
        int texelLog2;
        texelLog2 = sizeLog2 - $clog2(pixelWidth / 8);
        return texelLog2 - $clog2(streamWidth / pixelWidth);
    endfunction

endpackage

`default_nettype wire

/* design/texelAddressGen.sv */
/*
 * Texel address generator
 * Decodes size codes into the four quad addresses and registers the sub-texel fractions
 */
`default_nettype none
`timescale 1ns/1ns

module texelAddressGen (
    input  wire                               aclk,
    input  wire textureBufferPkg::textureSizeT textureSize,
    input  wire textureBufferPkg::texelCoordT  texelCoord,
    output textureBufferPkg::quadAddrT         quadAddr,
    output textureBufferPkg::subCoordT         subCoord
);

    localparam int cw = textureBufferPkg::coordWidth;

    // Index bits of an axis, zero for a 1-texel axis
    function automatic logic [3:0] sizeBits(
        input logic [textureBufferPkg::sizeCodeWidth-1:0] code
    );
        case (code)
            8'b0000_0001: sizeBits = 4'd1;
            8'b0000_0010: sizeBits = 4'd2;
            8'b0000_0100: sizeBits = 4'd3;
            8'b0000_1000: sizeBits = 4'd4;
            8'b0001_0000: sizeBits = 4'd5;
            8'b0010_0000: sizeBits = 4'd6;
            8'b0100_0000: sizeBits = 4'd7;
            8'b1000_0000: sizeBits = 4'd8;
            default:      sizeBits = 4'd0;
        endcase
    endfunction

    // Top n fraction bits below bit 15, masking also wraps the neighbour
    function automatic logic [7:0] axisIndex(input logic [cw-1:0] c, input logic [3:0] n);
        logic [cw-1:0] shifted;
        logic [8:0]    mask;
        shifted = c >> (4'd15 - n);
        mask = (9'd1 << n) - 9'd1;
        axisIndex = shifted[7:0] & mask[7:0];
    endfunction

    function automatic logic [cw-1:0] axisFraction(input logic [cw-1:0] c, input logic [3:0] n);
        if (n == 4'd0)
        begin
            axisFraction = '0;
        end
        else
        begin
            axisFraction = c << (n + 4'd1);
        end
    endfunction

    // Row index sits above the column index
    function automatic textureBufferPkg::texelAddrT texelAddress(
        input logic [7:0] iy,
        input logic [7:0] ix,
        input logic [3:0] nX
    );
        texelAddress = ({8'd0, iy} << nX) | {8'd0, ix};
    endfunction

    logic [3:0]    nX;
    logic [3:0]    nY;
    logic [cw-1:0] xNext;
    logic [cw-1:0] yNext;
    logic [7:0]    ix0;
    logic [7:0]    ix1;
    logic [7:0]    iy0;
    logic [7:0]    iy1;

    textureBufferPkg::subCoordT subNext;

    always_comb
    begin
        nX = sizeBits(textureSize.sizeX);
        nY = sizeBits(textureSize.sizeY);

        // One texel step ahead on each axis
        xNext = texelCoord.x + (cw'(1) << (4'd15 - nX));
        yNext = texelCoord.y + (cw'(1) << (4'd15 - nY));

        ix0 = axisIndex(texelCoord.x, nX);
        ix1 = axisIndex(xNext, nX);
        iy0 = axisIndex(texelCoord.y, nY);
        iy1 = axisIndex(yNext, nY);

        quadAddr.t00 = texelAddress(iy0, ix0, nX);
        quadAddr.t01 = texelAddress(iy0, ix1, nX);
        quadAddr.t10 = texelAddress(iy1, ix0, nX);
        quadAddr.t11 = texelAddress(iy1, ix1, nX);

        subNext.x = axisFraction(texelCoord.x, nX);
        subNext.y = axisFraction(texelCoord.y, nY);
    end

    // In step with the bank read
    always_ff @(posedge aclk)
    begin
        subCoord <= subNext;
    end

endmodule

`default_nettype wire

/* design/streamWriter.sv */
/*
 * Stream writer
 * Counts bank write addresses and splits each beat into even and odd X texels
 */
`default_nettype none
`timescale 1ns/1ns

module streamWriter #(
    parameter int streamWidth = 32,
    parameter int sizeLog2    = 14
)
(
    input  wire                   aclk,
    input  wire                   resetn,
    input  wire                   streamValid,
    input  wire                   streamLast,
    input  wire [streamWidth-1:0] streamData,
    output logic [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] writeAddr,
    output logic [streamWidth/2-1:0] evenData,
    output logic [streamWidth/2-1:0] oddData
);

    localparam int pw        = textureBufferPkg::pixelWidth;
    localparam int bankLanes = streamWidth / (2 * pw);

    // Wraps at the bank depth, restarts after a last beat
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writeAddr <= '0;
        end
        else if (streamValid)
        begin
            writeAddr <= streamLast ? '0 : writeAddr + 1'b1;
        end
    end

    // Texel 2i goes to the even bank, texel 2i+1 to the odd bank
    for (genvar i = 0; i < bankLanes; i++)
    begin : gStride
        assign evenData[i*pw +: pw] = streamData[(2*i)*pw +: pw];
        assign oddData[i*pw +: pw]  = streamData[(2*i+1)*pw +: pw];
    end

endmodule

`default_nettype wire

/* design/texelBank.sv */
/*
 * Texel memory bank
 * Shared write/read port for the write stream and row 1, read-only port for row 0
 */
`default_nettype none
`timescale 1ns/1ns

module texelBank #(
    parameter int streamWidth = 32,
    parameter int sizeLog2    = 14
)
(
    input  wire                            aclk,
    input  wire                            writeEnable,
    input  wire [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] writeAddr,
    input  wire [streamWidth/2-1:0]        writeData,
    input  wire [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] row1Addr,
    output logic [streamWidth/2-1:0]       row1Data,
    input  wire [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] row0Addr,
    output logic [streamWidth/2-1:0]       row0Data
);

    localparam int halfWidth = streamWidth / 2;

    // Half the buffer bytes, in half-beat words
    localparam int bankDepth = (2 ** (sizeLog2 - 1)) / (halfWidth / 8);

    logic [halfWidth-1:0] mem [bankDepth];

    // Write wins the port, the row 1 read is lost during a beat
    always_ff @(posedge aclk)
    begin
        if (writeEnable)
        begin
            mem[writeAddr] <= writeData;
        end
        else
        begin
            row1Data <= mem[row1Addr];
        end
    end

    always_ff @(posedge aclk)
    begin
        row0Data <= mem[row0Addr];
    end

    // Address width and byte size must describe the same bank
    writeInRange: assert property (
        @(posedge aclk) writeEnable |-> (int'(writeAddr) < bankDepth)
    );

endmodule

`default_nettype wire

/* design/quadSelect.sv */
/*
 * Quad selector
 * Routes quad addresses to the banks and picks the four texels from the bank words
 */
`default_nettype none
`timescale 1ns/1ns

module quadSelect #(
    parameter int streamWidth = 32,
    parameter int sizeLog2    = 14
)
(
    input  wire                             aclk,
    input  wire textureBufferPkg::quadAddrT  quadAddr,
    output logic [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] evenRow0Addr,
    output logic [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] oddRow0Addr,
    output logic [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] evenRow1Addr,
    output logic [textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2)-1:0] oddRow1Addr,
    input  wire [streamWidth/2-1:0]         evenRow0Data,
    input  wire [streamWidth/2-1:0]         oddRow0Data,
    input  wire [streamWidth/2-1:0]         evenRow1Data,
    input  wire [streamWidth/2-1:0]         oddRow1Data,
    output textureBufferPkg::texelQuadT      texelQuad
);

    localparam int pw        = textureBufferPkg::pixelWidth;
    localparam int halfWidth = streamWidth / 2;
    localparam int bankLanes = halfWidth / pw;
    localparam int bankAddrW = textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2);

    // Bank bit plus lane bits below the word address
    localparam int laneBits  = $clog2(streamWidth / pw);

    textureBufferPkg::quadAddrT decodeAddr;

    // Bank bit picks the word, the bits above it pick the lane
    function automatic logic [pw-1:0] pickTexel(
        input textureBufferPkg::texelAddrT addr,
        input logic [halfWidth-1:0]        evenWord,
        input logic [halfWidth-1:0]        oddWord
    );
        logic [halfWidth-1:0] word;
        int unsigned          lane;
        word = addr[0] ? oddWord : evenWord;
        lane = (addr >> 1) & (bankLanes - 1);
        pickTexel = word[lane*pw +: pw];
    endfunction

    // t00 and t01 sit in opposite banks, so does the second row
    always_comb
    begin
        evenRow0Addr = quadAddr.t00[0] ? quadAddr.t01[laneBits +: bankAddrW]
                                       : quadAddr.t00[laneBits +: bankAddrW];
        oddRow0Addr  = quadAddr.t00[0] ? quadAddr.t00[laneBits +: bankAddrW]
                                       : quadAddr.t01[laneBits +: bankAddrW];
        evenRow1Addr = quadAddr.t10[0] ? quadAddr.t11[laneBits +: bankAddrW]
                                       : quadAddr.t10[laneBits +: bankAddrW];
        oddRow1Addr  = quadAddr.t10[0] ? quadAddr.t10[laneBits +: bankAddrW]
                                       : quadAddr.t11[laneBits +: bankAddrW];
    end

    always_ff @(posedge aclk)
    begin
        decodeAddr <= quadAddr;
    end

    always_comb
    begin
        texelQuad.t00 = pickTexel(decodeAddr.t00, evenRow0Data, oddRow0Data);
        texelQuad.t01 = pickTexel(decodeAddr.t01, evenRow0Data, oddRow0Data);
        texelQuad.t10 = pickTexel(decodeAddr.t10, evenRow1Data, oddRow1Data);
        texelQuad.t11 = pickTexel(decodeAddr.t11, evenRow1Data, oddRow1Data);
    end

    // Neighbours on a row need both banks, unless the row is a single texel
    row0Banks: assert property (
        @(posedge aclk) (quadAddr.t00[0] != quadAddr.t01[0]) || (quadAddr.t00 == quadAddr.t01)
    );

    row1Banks: assert property (
        @(posedge aclk) (quadAddr.t10[0] != quadAddr.t11[0]) || (quadAddr.t10 == quadAddr.t11)
    );

endmodule

`default_nettype wire

/* design/textureBuffer.sv */
/*
 * Texture buffer top level
 * Stores a streamed texture in two banks and returns a 2x2 texel quad per cycle
 */
`default_nettype none
`timescale 1ns/1ns

module textureBuffer #(
    parameter int streamWidth = 32,
    parameter int sizeLog2    = 14
)
(
    input  wire                               aclk,
    input  wire                               resetn,

    input  wire textureBufferPkg::textureSizeT textureSize,

    input  wire textureBufferPkg::texelCoordT  texelCoord,
    output textureBufferPkg::texelQuadT        texelQuad,
    output textureBufferPkg::subCoordT         subCoord,

    input  wire                               streamValid,
    input  wire                               streamLast,
    input  wire [streamWidth-1:0]             streamData
);

    localparam int bankAddrW = textureBufferPkg::bankAddrWidth(streamWidth, sizeLog2);
    localparam int halfWidth = streamWidth / 2;

    textureBufferPkg::quadAddrT quadAddr;

    logic [bankAddrW-1:0] writeAddr;
    logic [halfWidth-1:0] evenData;
    logic [halfWidth-1:0] oddData;

    logic [bankAddrW-1:0] evenRow0Addr;
    logic [bankAddrW-1:0] oddRow0Addr;
    logic [bankAddrW-1:0] evenRow1Addr;
    logic [bankAddrW-1:0] oddRow1Addr;
    logic [halfWidth-1:0] evenRow0Data;
    logic [halfWidth-1:0] oddRow0Data;
    logic [halfWidth-1:0] evenRow1Data;
    logic [halfWidth-1:0] oddRow1Data;

    texelAddressGen u_texelAddressGen (
        .aclk        (aclk),
        .textureSize (textureSize),
        .texelCoord  (texelCoord),
        .quadAddr    (quadAddr),
        .subCoord    (subCoord)
    );

    streamWriter #(
        .streamWidth (streamWidth),
        .sizeLog2    (sizeLog2)
    ) u_streamWriter (
        .aclk        (aclk),
        .resetn      (resetn),
        .streamValid (streamValid),
        .streamLast  (streamLast),
        .streamData  (streamData),
        .writeAddr   (writeAddr),
        .evenData    (evenData),
        .oddData     (oddData)
    );

    // Even X texels
    texelBank #(
        .streamWidth (streamWidth),
        .sizeLog2    (sizeLog2)
    ) evenBank (
        .aclk        (aclk),
        .writeEnable (streamValid),
        .writeAddr   (writeAddr),
        .writeData   (evenData),
        .row1Addr    (evenRow1Addr),
        .row1Data    (evenRow1Data),
        .row0Addr    (evenRow0Addr),
        .row0Data    (evenRow0Data)
    );

    // Odd X texels
    texelBank #(
        .streamWidth (streamWidth),
        .sizeLog2    (sizeLog2)
    ) oddBank (
        .aclk        (aclk),
        .writeEnable (streamValid),
        .writeAddr   (writeAddr),
        .writeData   (oddData),
        .row1Addr    (oddRow1Addr),
        .row1Data    (oddRow1Data),
        .row0Addr    (oddRow0Addr),
        .row0Data    (oddRow0Data)
    );

    quadSelect #(
        .streamWidth (streamWidth),
        .sizeLog2    (sizeLog2)
    ) u_quadSelect (
        .aclk         (aclk),
        .quadAddr     (quadAddr),
        .evenRow0Addr (evenRow0Addr),
        .oddRow0Addr  (oddRow0Addr),
        .evenRow1Addr (evenRow1Addr),
        .oddRow1Addr  (oddRow1Addr),
        .evenRow0Data (evenRow0Data),
        .oddRow0Data  (oddRow0Data),
        .evenRow1Data (evenRow1Data),
        .oddRow1Data  (oddRow1Data),
        .texelQuad    (texelQuad)
    );

endmodule

`default_nettype wire

/* tests/textureModel.svh */
/*
 * Texture buffer reference model
 * Texel image in stream order, expected quad and sub-texel fractions
 */
`ifndef TEXTURE_MODEL_SVH
`define TEXTURE_MODEL_SVH

// Texel 2b+lane of stream beat b
logic [15:0] textureImage [8192];

// Index bits of one axis, 0 for a 1-texel axis
function automatic int axisLog2(input logic [7:0] code);
    int n;
    int k;
    n = 0;
    if ($countones(code) == 1)
    begin
        for (k = 0; k < 8; k++)
        begin
            if (code[k])
            begin
                n = k + 1;
            end
        end
    end
    return n;
endfunction

// Fraction scaled by the axis size, step 1 is the wrapped neighbour
function automatic int axisPos(input logic [15:0] c, input int n, input int step);
    int pos;
    pos = (int'(c[14:0]) << n) >> 15;
    return (pos + step) % (1 << n);
endfunction

// Fraction bits left over below the index, moved up to bit 15
function automatic logic [15:0] axisFrac(input logic [15:0] c, input int n);
    int scaled;
    scaled = (int'(c[14:0]) << n) & 32'h7fff;
    if (n == 0)
    begin
        return 16'h0000;
    end
    return 16'(scaled << 1);
endfunction

function automatic textureBufferPkg::texelQuadT expectQuad(
    input textureBufferPkg::textureSizeT size,
    input textureBufferPkg::texelCoordT  coord
);
    int nX;
    int nY;
    int x0;
    int x1;
    int y0;
    int y1;
    textureBufferPkg::texelQuadT q;
    nX = axisLog2(size.sizeX);
    nY = axisLog2(size.sizeY);
    x0 = axisPos(coord.x, nX, 0);
    x1 = axisPos(coord.x, nX, 1);
    y0 = axisPos(coord.y, nY, 0);
    y1 = axisPos(coord.y, nY, 1);
    // Rows are sizeX texels long
    q.t00 = textureImage[(y0 << nX) + x0];
    q.t01 = textureImage[(y0 << nX) + x1];
    q.t10 = textureImage[(y1 << nX) + x0];
    q.t11 = textureImage[(y1 << nX) + x1];
    return q;
endfunction

function automatic textureBufferPkg::subCoordT expectSub(
    input textureBufferPkg::textureSizeT size,
    input textureBufferPkg::texelCoordT  coord
);
    textureBufferPkg::subCoordT s;
    s.x = axisFrac(coord.x, axisLog2(size.sizeX));
    s.y = axisFrac(coord.y, axisLog2(size.sizeY));
    return s;
endfunction

`endif

/* tests/textureBufferTb.sv */
/*
 * Texture buffer testbench
 * Streams random textures, reads quads and checks them against a model
 */
`default_nettype none
`timescale 1ns/1ns

module textureBufferTb;

    localparam int streamWidth = 32;
    localparam int sizeLog2    = 14;
    localparam int maxCycles   = 40000;

    logic                   aclk;
    logic                   resetn;
    logic                   streamValid;
    logic                   streamLast;
    logic [streamWidth-1:0] streamData;

    textureBufferPkg::textureSizeT textureSize;
    textureBufferPkg::texelCoordT  texelCoord;
    textureBufferPkg::texelQuadT   texelQuad;
    textureBufferPkg::subCoordT    subCoord;

    int seed;
    int errorCount;
    int checkCount;

    textureBufferPkg::texelCoordT coordQueue [$];

    `include "textureModel.svh"

    textureBuffer #(
        .streamWidth (streamWidth),
        .sizeLog2    (sizeLog2)
    ) u_textureBuffer (
        .aclk        (aclk),
        .resetn      (resetn),
        .textureSize (textureSize),
        .texelCoord  (texelCoord),
        .texelQuad   (texelQuad),
        .subCoord    (subCoord),
        .streamValid (streamValid),
        .streamLast  (streamLast),
        .streamData  (streamData)
    );

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #10 aclk = ~aclk;
        end
    end

    // Bounds the whole run
    initial
    begin
        int cycles;
        for (cycles = 0; cycles < maxCycles; cycles++)
        begin
            @(posedge aclk);
        end
        $display("Timeout: run still busy after %0d cycles", maxCycles);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // One beat per cycle, last strobe on the final beat
    task automatic loadTexture(input int beats);
        int          b;
        logic [31:0] beat;
        for (b = 0; b < beats; b++)
        begin
            @(posedge aclk);
            beat = $random(seed);
            streamValid <= 1'b1;
            streamLast  <= (b == beats - 1);
            streamData  <= beat;
            textureImage[2*b]   = beat[15:0];
            textureImage[2*b+1] = beat[31:16];
        end
        @(posedge aclk);
        streamValid <= 1'b0;
        streamLast  <= 1'b0;
    endtask

    task automatic setSize(input logic [7:0] codeX, input logic [7:0] codeY);
        @(posedge aclk);
        textureSize <= {codeX, codeY};
    endtask

    // Queued coordinates go out back to back, each result is due one edge later
    task automatic runReads();
        int                           i;
        int                           count;
        string                        where;
        textureBufferPkg::texelCoordT c;
        textureBufferPkg::texelQuadT  quad;
        textureBufferPkg::subCoordT   sub;
        count = coordQueue.size();
        for (i = 0; i <= count; i++)
        begin
            @(posedge aclk);
            if (i < count)
            begin
                texelCoord <= coordQueue[i];
            end
            @(negedge aclk);
            if (i > 0)
            begin
                c = coordQueue[i-1];
                quad = expectQuad(textureSize, c);
                sub = expectSub(textureSize, c);
                where = $sformatf(" at x %h y %h size %h", c.x, c.y, textureSize);
                checkValue(texelQuad.t00, quad.t00, {"t00", where});
                checkValue(texelQuad.t01, quad.t01, {"t01", where});
                checkValue(texelQuad.t10, quad.t10, {"t10", where});
                checkValue(texelQuad.t11, quad.t11, {"t11", where});
                checkValue(subCoord.x, sub.x, {"subCoord x", where});
                checkValue(subCoord.y, sub.y, {"subCoord y", where});
            end
        end
        coordQueue.delete();
    endtask

    task automatic randomReads(input int count);
        int                           i;
        textureBufferPkg::texelCoordT c;
        for (i = 0; i < count; i++)
        begin
            c = $random(seed);
            coordQueue.push_back(c);
        end
        runReads();
    endtask

    initial
    begin
        int                           i;
        int                           kx;
        int                           ky;
        logic [7:0]                   codeX;
        logic [7:0]                   codeY;
        textureBufferPkg::texelCoordT c;

        seed = 32'h2909_6e44;
        errorCount = 0;
        checkCount = 0;
        resetn = 1'b0;
        textureSize = '0;
        texelCoord = '0;
        streamValid = 1'b0;
        streamLast = 1'b0;
        streamData = '0;
        for (i = 0; i < 16; i++)
        begin
            @(posedge aclk);
        end
        resetn <= 1'b1;

        // 64x64 texture, single reads with idle cycles between
        loadTexture(2048);
        setSize(8'h20, 8'h20);
        for (i = 0; i < 200; i++)
        begin
            randomReads(1);
        end

        // Last texel on both axes, neighbours wrap to index 0
        for (i = 0; i < 32; i++)
        begin
            c = $random(seed);
            c.x[14:9] = 6'h3f;
            c.y[14:9] = 6'h3f;
            coordQueue.push_back(c);
        end
        runReads();

        randomReads(256);

        // Full buffer, starts at 0 only if the last beat above restarted the counter
        loadTexture(4096);
        for (i = 0; i < 24; i++)
        begin
            kx = {$random(seed)} % 8;
            ky = {$random(seed)} % 8;
            codeX = (kx == 7) ? 8'h00 : 8'(1 << kx);
            codeY = (ky == 7) ? 8'h00 : 8'(1 << ky);
            if (axisLog2(codeX) + axisLog2(codeY) > 13)
            begin
                codeY = 8'h00;
            end
            setSize(codeX, codeY);
            randomReads(16);
        end

        // Zero and multi-bit size codes
        codeX = 8'($random(seed)) | 8'h03;
        setSize(8'h00, 8'h20);
        randomReads(16);
        setSize(codeX, 8'h20);
        randomReads(16);
        setSize(8'h20, codeX | 8'h40);
        randomReads(16);
        setSize(8'h00, codeX);
        randomReads(16);

        // Short stream covers rows 0 to 7 of a 64x64 texture
        loadTexture(256);
        setSize(8'h20, 8'h20);
        for (i = 0; i < 64; i++)
        begin
            c = $random(seed);
            if (i % 2 == 0)
            begin
                c.y[14:12] = 3'b000;
            end
            else
            begin
                c.y[14] = 1'b1;
            end
            coordQueue.push_back(c);
        end
        runReads();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
design/textureBufferPkg.sv
design/texelAddressGen.sv
design/streamWriter.sv
design/texelBank.sv
design/quadSelect.sv
design/textureBuffer.sv
tests/textureBufferTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module textureBufferTb -o textureBufferSim

out=$(./obj_dir/textureBufferSim)
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
